// ==== rtl/i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// each byte state is followed directly by its ACK state
	typedef enum logic [7:0] {
		IDLE      = 8'd0,
		START     = 8'd1,
		ADDR      = 8'd2,
		ADDR_ACK  = 8'd3,
		REG       = 8'd4,
		REG_ACK   = 8'd5,
		WDATA     = 8'd6,
		WDATA_ACK = 8'd7,
		RDATA     = 8'd8,
		MACK      = 8'd9,  // master ACK or final NACK
		STOP      = 8'd10,
		STOP_END  = 8'd11
	} seq_state_e;

	// SCL period is 2^(code+1) system clocks
	typedef logic [2:0] rate_code_t;

	localparam rate_code_t RATE_MIN     = 3'd4; // 32 clocks per bit
	localparam rate_code_t RATE_MAX     = 3'd7; // 256 clocks per bit
	localparam rate_code_t RATE_DEFAULT = 3'd6;

	// one-cycle strobes, at most one per cycle
	typedef struct packed {
		logic scl_rise;
		logic scl_high_mid; // sample point
		logic scl_fall;
		logic scl_low_mid;  // SDA change point
	} bus_phase_t;

endpackage

// ==== rtl/i2c_regs_pkg.sv ====
package i2c_regs_pkg;

	// code 3 is reserved and runs as CPU_ONE
	typedef enum logic [1:0] {
		CPU_ONE   = 2'd0,
		CPU_BURST = 2'd1,
		HW_BURST  = 2'd2
	} op_mode_e;

	// CPU control word
	typedef struct packed {
		logic [24:0] unused;
		logic [2:0]  clk_rate;
		op_mode_e    op_mode;
		logic        rd;     // 1 selects a register read
		logic        enable; // level, sampled in IDLE
	} ctrl_word_t;

	// status word back to the CPU
	typedef struct packed {
		logic [20:0] zero;
		logic        nack;   // no ACK on the device address
		logic [7:0]  state;  // raw sequencer state
		logic        finish; // held until the next start
		logic        ready;
	} status_word_t;

endpackage

// ==== rtl/i2c_scl_timer.sv ====
`timescale 1ns/1ps

module i2c_scl_timer (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_run,
	input  i2c_bus_pkg::rate_code_t i_rate,
	output i2c_bus_pkg::bus_phase_t o_phase,
	output logic                    o_scl_level
);

	i2c_bus_pkg::rate_code_t rate_q; // frozen while a transaction runs
	logic [7:0] cnt;
	logic [7:0] wrap_mask;
	logic [7:0] quarter;
	logic [7:0] half;

	assign wrap_mask = 8'hff >> (3'd7 - rate_q);
	assign quarter   = 8'd1 << (rate_q - 3'd1);
	assign half      = quarter << 1;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rate_q <= i2c_bus_pkg::RATE_DEFAULT;
		end else if (!i_run) begin
			if (i_rate < i2c_bus_pkg::RATE_MIN || i_rate > i2c_bus_pkg::RATE_MAX)
				rate_q <= i2c_bus_pkg::RATE_DEFAULT; // unsupported code
			else
				rate_q <= i_rate;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			cnt <= '0;
		else if (!i_run)
			cnt <= '0;
		else
			cnt <= (cnt + 8'd1) & wrap_mask;
	end

	// bit period: high half first, so SCL stays high when the timer starts
	assign o_phase.scl_rise     = i_run && cnt == 8'd0;
	assign o_phase.scl_high_mid = i_run && cnt == quarter;
	assign o_phase.scl_fall     = i_run && cnt == half;
	assign o_phase.scl_low_mid  = i_run && cnt == (half + quarter);

	assign o_scl_level = !i_run || !cnt[rate_q];

	a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot0(o_phase));

endmodule

// ==== rtl/i2c_byte_shifter.sv ====
`timescale 1ns/1ps

module i2c_byte_shifter (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  i2c_bus_pkg::bus_phase_t i_phase,
	input  logic                    i_load,
	input  logic [7:0]              i_tx_byte,
	input  logic                    i_sda_in,
	output logic                    o_tx_bit,
	output logic [7:0]              o_rx_byte,
	output logic                    o_byte_done
);

	logic [7:0] tx_sr;
	logic [2:0] bit_cnt;
	logic       busy;

	// next bit to put on SDA, taken at low_mid
	assign o_tx_bit = tx_sr[7];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy        <= 1'b0;
			bit_cnt     <= '0;
			o_byte_done <= 1'b0;
		end else begin
			o_byte_done <= 1'b0;
			if (i_load) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
			end else if (busy && i_phase.scl_high_mid) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin // eighth sample taken
					busy        <= 1'b0;
					o_byte_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load)
			tx_sr <= i_tx_byte;
		else if (busy && i_phase.scl_low_mid)
			tx_sr <= {tx_sr[6:0], 1'b1}; // MSB first, fill with released level
		if (busy && i_phase.scl_high_mid)
			o_rx_byte <= {o_rx_byte[6:0], i_sda_in};
	end

	// the FSM only reloads after the ACK bit, never mid byte
	a_load_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_load |-> !busy);

endmodule

// ==== rtl/i2c_rd_bank.sv ====
`timescale 1ns/1ps

module i2c_rd_bank #(
	parameter int BURST_LEN = 11
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_wr,
	input  logic [3:0]             i_index,
	input  logic [7:0]             i_byte,
	output logic [BURST_LEN*8-1:0] o_bytes
);

	logic [7:0] bank [BURST_LEN];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int k = 0; k < BURST_LEN; k++)
				bank[k] <= '0;
		end else if (i_wr) begin
			bank[i_index] <= i_byte; // other entries keep their value
		end
	end

	// byte k of the burst lands at bits 8k+7:8k
	genvar g;
	generate
		for (g = 0; g < BURST_LEN; g++) begin : g_pack
			assign o_bytes[8*g +: 8] = bank[g];
		end
	endgenerate

	a_index_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr |-> i_index < BURST_LEN);

endmodule

// ==== rtl/i2c_seq_fsm.sv ====
`timescale 1ns/1ps

module i2c_seq_fsm #(
	parameter logic [6:0] SENSOR_ADDR = 7'h1D,
	parameter logic [7:0] SENSOR_REG  = 8'h06,
	parameter int         BURST_LEN   = 11
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  i2c_regs_pkg::ctrl_word_t   i_ctrl,
	input  logic                       i_drdy,
	input  logic [6:0]                 i_dev_addr,
	input  logic [7:0]                 i_reg_addr,
	input  logic [7:0]                 i_w_data,
	input  i2c_bus_pkg::bus_phase_t    i_phase,
	input  logic                       i_byte_done,
	input  logic                       i_tx_bit,
	input  logic                       i_sda_in,
	output logic                       o_run,
	output logic                       o_load,
	output logic [7:0]                 o_tx_byte,
	output logic                       o_sda_oe,
	output logic                       o_wr_strobe,
	output logic [3:0]                 o_wr_index,
	output i2c_regs_pkg::status_word_t o_status
);

	i2c_bus_pkg::seq_state_e state;
	logic       pending;  // address write sent, read transaction still owed
	logic       rd_phase; // R/W bit of the running transaction
	logic       burst_q;
	logic [3:0] byte_cnt;
	logic       finish_q;
	logic       nack_q;
	logic [6:0] dev_q;
	logic [7:0] reg_q;
	logic [7:0] data_q;
	logic       hw_req;
	logic       cpu_req;
	logic       start_new;
	logic       last_byte;

	assign hw_req    = i_ctrl.op_mode == i2c_regs_pkg::HW_BURST && i_drdy;
	assign cpu_req   = i_ctrl.op_mode != i2c_regs_pkg::HW_BURST && i_ctrl.enable;
	assign start_new = state == i2c_bus_pkg::IDLE && !pending && (hw_req || cpu_req);
	assign last_byte = !burst_q || byte_cnt == 4'(BURST_LEN - 1);

	assign o_run = state != i2c_bus_pkg::IDLE;

	always_ff @(posedge i_clk) begin
		if (start_new) begin
			dev_q  <= hw_req ? SENSOR_ADDR : i_dev_addr;
			reg_q  <= hw_req ? SENSOR_REG : i_reg_addr;
			data_q <= i_w_data;
		end
	end

	// load is one cycle late, so pick the byte by the state just entered
	always_comb begin
		case (state)
			i2c_bus_pkg::ADDR:  o_tx_byte = {dev_q, rd_phase};
			i2c_bus_pkg::REG:   o_tx_byte = reg_q;
			i2c_bus_pkg::WDATA: o_tx_byte = data_q;
			default:            o_tx_byte = 8'hff; // reads keep SDA released
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state       <= i2c_bus_pkg::IDLE;
			pending     <= 1'b0;
			rd_phase    <= 1'b0;
			burst_q     <= 1'b0;
			byte_cnt    <= '0;
			finish_q    <= 1'b0;
			nack_q      <= 1'b0;
			o_sda_oe    <= 1'b0;
			o_load      <= 1'b0;
			o_wr_strobe <= 1'b0;
			o_wr_index  <= '0;
		end else begin
			o_load      <= 1'b0;
			o_wr_strobe <= 1'b0;
			case (state)
				i2c_bus_pkg::IDLE: begin
					o_sda_oe <= 1'b0;
					if (pending) begin // second half of a register read
						pending  <= 1'b0;
						rd_phase <= 1'b1;
						state    <= i2c_bus_pkg::START;
					end else if (start_new) begin
						burst_q  <= i_ctrl.op_mode inside {i2c_regs_pkg::CPU_BURST,
							i2c_regs_pkg::HW_BURST};
						pending  <= hw_req || i_ctrl.rd ||
							i_ctrl.op_mode == i2c_regs_pkg::CPU_BURST;
						rd_phase <= 1'b0;
						finish_q <= 1'b0;
						nack_q   <= 1'b0;
						state    <= i2c_bus_pkg::START;
					end
				end
				i2c_bus_pkg::START: begin
					if (i_phase.scl_high_mid) begin
						o_sda_oe <= 1'b1; // SDA falls while SCL is high
						o_load   <= 1'b1;
						state    <= i2c_bus_pkg::ADDR;
					end
				end
				i2c_bus_pkg::ADDR, i2c_bus_pkg::REG, i2c_bus_pkg::WDATA: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= !i_tx_bit;
					if (i_byte_done)
						state <= i2c_bus_pkg::seq_state_e'(state + 8'd1); // its ACK state
				end
				i2c_bus_pkg::ADDR_ACK: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= 1'b0;
					if (i_phase.scl_high_mid) begin
						if (i_sda_in) begin // nobody answered
							nack_q  <= 1'b1;
							pending <= 1'b0;
							state   <= i2c_bus_pkg::STOP;
						end else if (rd_phase) begin
							byte_cnt <= '0;
							o_load   <= 1'b1;
							state    <= i2c_bus_pkg::RDATA;
						end else begin
							o_load <= 1'b1;
							state  <= i2c_bus_pkg::REG;
						end
					end
				end
				i2c_bus_pkg::REG_ACK: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= 1'b0;
					if (i_phase.scl_high_mid) begin
						if (pending) begin
							state <= i2c_bus_pkg::STOP; // address write only
						end else begin
							o_load <= 1'b1;
							state  <= i2c_bus_pkg::WDATA;
						end
					end
				end
				i2c_bus_pkg::WDATA_ACK: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= 1'b0;
					if (i_phase.scl_high_mid)
						state <= i2c_bus_pkg::STOP;
				end
				i2c_bus_pkg::RDATA: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= 1'b0;
					if (i_byte_done) begin
						o_wr_strobe <= 1'b1;
						o_wr_index  <= byte_cnt;
						state       <= i2c_bus_pkg::MACK;
					end
				end
				i2c_bus_pkg::MACK: begin
					if (i_phase.scl_low_mid)
						o_sda_oe <= !last_byte; // NACK ends the burst
					if (i_phase.scl_high_mid) begin
						if (last_byte) begin
							state <= i2c_bus_pkg::STOP;
						end else begin
							byte_cnt <= byte_cnt + 4'd1;
							o_load   <= 1'b1;
							state    <= i2c_bus_pkg::RDATA;
						end
					end
				end
				i2c_bus_pkg::STOP: begin
					if (i_phase.scl_fall)
						o_sda_oe <= 1'b1; // pull SDA low under SCL low
					if (i_phase.scl_rise)
						state <= i2c_bus_pkg::STOP_END;
				end
				i2c_bus_pkg::STOP_END: begin
					if (i_phase.scl_high_mid) begin
						o_sda_oe <= 1'b0; // SDA rises with SCL high
						finish_q <= !pending;
						state    <= i2c_bus_pkg::IDLE;
					end
				end
				default: state <= i2c_bus_pkg::IDLE;
			endcase
		end
	end

	always_comb begin
		o_status        = '0;
		o_status.ready  = state == i2c_bus_pkg::IDLE && !pending;
		o_status.finish = finish_q;
		o_status.state  = state;
		o_status.nack   = nack_q;
	end

	a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		state inside {[i2c_bus_pkg::IDLE : i2c_bus_pkg::STOP_END]});

endmodule

// ==== rtl/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top #(
	parameter logic [6:0] SENSOR_ADDR = 7'h1D,
	parameter logic [7:0] SENSOR_REG  = 8'h06,
	parameter int         BURST_LEN   = 11
) (
	input  logic                       i_clk,
	input  logic                       i_rst_n,
	input  i2c_regs_pkg::ctrl_word_t   i_ctrl,
	input  logic                       i_drdy,
	input  logic [6:0]                 i_dev_addr,
	input  logic [7:0]                 i_reg_addr,
	input  logic [7:0]                 i_w_data,
	input  logic                       i_sda_in,
	output logic [BURST_LEN*8-1:0]     o_rd_bytes,
	output i2c_regs_pkg::status_word_t o_status,
	output logic                       o_scl,
	output logic                       o_sda_oe
);

	i2c_bus_pkg::bus_phase_t phase;
	logic       run;
	logic       scl_level;
	logic       load;
	logic [7:0] tx_byte;
	logic       tx_bit;
	logic [7:0] rx_byte;
	logic       byte_done;
	logic       sda_oe;
	logic       wr_strobe;
	logic [3:0] wr_index;
	logic [1:0] sda_sync; // SDA comes back from the pad

	// registered pad drive keeps SCL and SDA glitch free and aligned
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_scl    <= 1'b1;
			o_sda_oe <= 1'b0;
			sda_sync <= 2'b11;
		end else begin
			o_scl    <= scl_level;
			o_sda_oe <= sda_oe;
			sda_sync <= {sda_sync[0], i_sda_in};
		end
	end

	i2c_scl_timer u_timer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_run       (run),
		.i_rate      (i_ctrl.clk_rate),
		.o_phase     (phase),
		.o_scl_level (scl_level)
	);

	i2c_byte_shifter u_shifter (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_phase     (phase),
		.i_load      (load),
		.i_tx_byte   (tx_byte),
		.i_sda_in    (sda_sync[1]),
		.o_tx_bit    (tx_bit),
		.o_rx_byte   (rx_byte),
		.o_byte_done (byte_done)
	);

	i2c_rd_bank #(
		.BURST_LEN (BURST_LEN)
	) u_bank (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (wr_strobe),
		.i_index (wr_index),
		.i_byte  (rx_byte),
		.o_bytes (o_rd_bytes)
	);

	i2c_seq_fsm #(
		.SENSOR_ADDR (SENSOR_ADDR),
		.SENSOR_REG  (SENSOR_REG),
		.BURST_LEN   (BURST_LEN)
	) u_fsm (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_ctrl      (i_ctrl),
		.i_drdy      (i_drdy),
		.i_dev_addr  (i_dev_addr),
		.i_reg_addr  (i_reg_addr),
		.i_w_data    (i_w_data),
		.i_phase     (phase),
		.i_byte_done (byte_done),
		.i_tx_bit    (tx_bit),
		.i_sda_in    (sda_sync[1]),
		.o_run       (run),
		.o_load      (load),
		.o_tx_byte   (tx_byte),
		.o_sda_oe    (sda_oe),
		.o_wr_strobe (wr_strobe),
		.o_wr_index  (wr_index),
		.o_status    (o_status)
	);

endmodule

// ==== tests/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h1D
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_oe
);

	typedef enum logic [1:0] {SL_IDLE, SL_ADDR, SL_RX, SL_TX} slave_mode_e;

	logic [7:0]  mem [256];
	slave_mode_e mode;
	logic        scl_q;
	logic        sda_q;
	logic [3:0]  bit_cnt; // SCL rises seen in the current 9-bit frame
	logic [7:0]  shreg;
	logic [7:0]  ptr;     // register pointer, auto increments
	logic        got_reg;
	logic        rw;
	logic        m_ack;

	// bus edges are found by oversampling with the system clock
	always @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode     <= SL_IDLE;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
			bit_cnt  <= '0;
			shreg    <= '0;
			ptr      <= '0;
			got_reg  <= 1'b0;
			rw       <= 1'b0;
			m_ack    <= 1'b0;
			o_sda_oe <= 1'b0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_scl && scl_q && sda_q && !i_sda) begin // START
				mode     <= SL_ADDR;
				bit_cnt  <= '0;
				got_reg  <= 1'b0;
				o_sda_oe <= 1'b0;
			end else if (i_scl && scl_q && !sda_q && i_sda) begin // STOP
				mode     <= SL_IDLE;
				o_sda_oe <= 1'b0;
			end else if (mode != SL_IDLE && i_scl && !scl_q) begin
				bit_cnt <= bit_cnt + 4'd1;
				if (bit_cnt < 4'd8 && mode != SL_TX)
					shreg <= {shreg[6:0], i_sda};
				if (bit_cnt == 4'd8 && mode == SL_TX)
					m_ack <= !i_sda; // low means the master wants more
			end else if (mode != SL_IDLE && !i_scl && scl_q) begin
				if (bit_cnt == 4'd8) begin
					// ACK slot starts
					if (mode == SL_ADDR) begin
						if (shreg[7:1] == DEV_ADDR) begin
							o_sda_oe <= 1'b1;
							rw       <= shreg[0];
						end else begin
							mode <= SL_IDLE; // not addressed, stay quiet
						end
					end else if (mode == SL_RX) begin
						o_sda_oe <= 1'b1;
						if (!got_reg) begin
							ptr     <= shreg;
							got_reg <= 1'b1;
						end else begin
							mem[ptr] = shreg;
							ptr     <= ptr + 8'd1;
						end
					end else begin
						o_sda_oe <= 1'b0; // master drives its ACK
					end
				end else if (bit_cnt == 4'd9) begin
					bit_cnt  <= '0;
					o_sda_oe <= 1'b0;
					if ((mode == SL_ADDR && rw) || (mode == SL_TX && m_ack)) begin
						mode     <= SL_TX;
						shreg    <= mem[ptr];
						ptr      <= ptr + 8'd1;
						o_sda_oe <= !mem[ptr][7];
					end else if (mode == SL_ADDR) begin
						mode <= SL_RX;
					end else if (mode == SL_TX) begin
						mode <= SL_IDLE; // NACK ends the read
					end
				end else if (bit_cnt != 4'd0 && mode == SL_TX) begin
					shreg    <= shreg << 1;
					o_sda_oe <= !shreg[6];
				end
			end
		end
	end

endmodule

// ==== tests/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;

	localparam logic [6:0] SENSOR_ADDR    = 7'h1D;
	localparam logic [7:0] SENSOR_REG     = 8'h06;
	localparam int         BURST_LEN      = 11;
	localparam int         NUM_TESTS      = 12;
	localparam int         TIMEOUT_CYCLES = NUM_TESTS * 400 * 256;

	typedef struct packed {
		i2c_regs_pkg::op_mode_e op_mode;
		logic                   rd;
		logic [6:0]             dev;
		logic [7:0]             reg_addr;
		logic [7:0]             data;
		logic [2:0]             rate;
		logic                   exp_nack;
	} test_entry_t;

	logic                       clk;
	logic                       rst_n;
	i2c_regs_pkg::ctrl_word_t   ctrl;
	logic                       drdy;
	logic [6:0]                 dev_addr;
	logic [7:0]                 reg_addr;
	logic [7:0]                 w_data;
	logic [BURST_LEN*8-1:0]     rd_bytes;
	i2c_regs_pkg::status_word_t status;
	logic                       scl;
	logic                       master_oe;
	logic                       slave_oe;
	logic                       sda;

	test_entry_t tests [NUM_TESTS];
	logic [7:0]  mirror [256]; // expected slave memory
	integer      seed;
	int          cycle_count;
	int          check_count;
	int          error_count;

	// wired-AND with pull-up: either side pulls low
	assign sda = !master_oe && !slave_oe;

	i2c_master_top #(
		.SENSOR_ADDR (SENSOR_ADDR),
		.SENSOR_REG  (SENSOR_REG),
		.BURST_LEN   (BURST_LEN)
	) dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_ctrl     (ctrl),
		.i_drdy     (drdy),
		.i_dev_addr (dev_addr),
		.i_reg_addr (reg_addr),
		.i_w_data   (w_data),
		.i_sda_in   (sda),
		.o_rd_bytes (rd_bytes),
		.o_status   (status),
		.o_scl      (scl),
		.o_sda_oe   (master_oe)
	);

	i2c_slave_model #(
		.DEV_ADDR (SENSOR_ADDR)
	) slave (
		.i_clk    (clk),
		.i_rst_n  (rst_n),
		.i_scl    (scl),
		.i_sda    (sda),
		.o_sda_oe (slave_oe)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic wait_cycle();
		@(posedge clk);
		#1; // drive and sample just after the edge
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got == exp) else begin
			error_count++;
			$display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// one bit time is 2^(code+1) clocks, bad codes fall back to code 6
	function automatic int scl_period(input logic [2:0] code);
		if (code >= 3'd4)
			return 1 << (int'(code) + 1);
		return 128;
	endfunction

	task automatic fill_table();
		tests[0]  = '{i2c_regs_pkg::CPU_ONE,   1'b0, 7'h1D, 8'h10, 8'hA5, 3'd4, 1'b0};
		tests[1]  = '{i2c_regs_pkg::CPU_ONE,   1'b1, 7'h1D, 8'h10, 8'h00, 3'd5, 1'b0};
		tests[2]  = '{i2c_regs_pkg::CPU_ONE,   1'b0, 7'h1D, 8'h3F, 8'h3C, 3'd6, 1'b0};
		tests[3]  = '{i2c_regs_pkg::CPU_ONE,   1'b1, 7'h1D, 8'h3F, 8'h00, 3'd7, 1'b0};
		tests[4]  = '{i2c_regs_pkg::CPU_BURST, 1'b0, 7'h1D, 8'h20, 8'h00, 3'd4, 1'b0};
		tests[5]  = '{i2c_regs_pkg::CPU_BURST, 1'b0, 7'h1D, 8'hF8, 8'h00, 3'd5, 1'b0};
		tests[6]  = '{i2c_regs_pkg::HW_BURST,  1'b0, 7'h22, 8'h77, 8'h00, 3'd6, 1'b0};
		tests[7]  = '{i2c_regs_pkg::CPU_ONE,   1'b0, 7'h2A, 8'h05, 8'h99, 3'd4, 1'b1};
		tests[8]  = '{i2c_regs_pkg::CPU_BURST, 1'b0, 7'h50, 8'h10, 8'h00, 3'd7, 1'b1};
		tests[9]  = '{i2c_regs_pkg::CPU_ONE,   1'b1, 7'h1D, 8'h06, 8'h00, 3'd2, 1'b0};
		tests[10] = '{i2c_regs_pkg::CPU_ONE,   1'b0, 7'h1D, 8'h08, 8'h5A, 3'd0, 1'b0};
		tests[11] = '{i2c_regs_pkg::HW_BURST,  1'b1, 7'h41, 8'h00, 8'h00, 3'd3, 1'b0};
	endtask

	task automatic run_entry(input int idx);
		test_entry_t            t;
		logic [BURST_LEN*8-1:0] exp_bank;
		logic [7:0]             base;
		int                     cyc;
		int                     first_rise;
		int                     period;
		int                     rises;
		logic                   scl_prev;
		t          = tests[idx];
		exp_bank   = rd_bytes;
		cyc        = 0;
		first_rise = 0;
		period     = 0;
		rises      = 0;
		ctrl          = '0;
		ctrl.op_mode  = t.op_mode;
		ctrl.rd       = t.rd;
		ctrl.clk_rate = t.rate;
		dev_addr      = t.dev;
		reg_addr      = t.reg_addr;
		w_data        = t.data;
		wait_cycle(); // rate settles while idle
		if (t.op_mode == i2c_regs_pkg::HW_BURST)
			drdy = 1'b1;
		else
			ctrl.enable = 1'b1;
		wait_cycle();
		drdy        = 1'b0;
		ctrl.enable = 1'b0;
		expect_equal($sformatf("entry %0d ready after request", idx), status.ready, 0);
		scl_prev = scl;
		while (!status.finish) begin
			wait_cycle();
			cyc++;
			if (scl && !scl_prev) begin
				rises++;
				if (rises == 1)
					first_rise = cyc;
				else if (rises == 2)
					period = cyc - first_rise; // two bit starts in a row
			end
			scl_prev = scl;
		end
		base = (t.op_mode == i2c_regs_pkg::HW_BURST) ? SENSOR_REG : t.reg_addr;
		if (!t.exp_nack) begin
			if (t.op_mode == i2c_regs_pkg::CPU_ONE) begin
				if (t.rd)
					exp_bank[7:0] = mirror[base];
				else
					mirror[base] = t.data;
			end else begin
				for (int k = 0; k < BURST_LEN; k++)
					exp_bank[8*k +: 8] = mirror[8'(base + k)]; // pointer wraps at 256
			end
		end
		expect_equal($sformatf("entry %0d nack", idx), status.nack, t.exp_nack);
		expect_equal($sformatf("entry %0d ready at finish", idx), status.ready, 1);
		expect_equal($sformatf("entry %0d state at finish", idx), status.state, 0);
		expect_equal($sformatf("entry %0d SCL period", idx), period, scl_period(t.rate));
		for (int k = 0; k < BURST_LEN; k++)
			expect_equal($sformatf("entry %0d byte %0d", idx, k), rd_bytes[8*k +: 8],
				exp_bank[8*k +: 8]);
	endtask

	initial begin
		rst_n       = 1'b0;
		ctrl        = '0;
		drdy        = 1'b0;
		dev_addr    = '0;
		reg_addr    = '0;
		w_data      = '0;
		check_count = 0;
		error_count = 0;
		seed        = 32'hb5c8a340;
		for (int k = 0; k < 256; k++) begin
			mirror[k]    = 8'($random(seed));
			slave.mem[k] = mirror[k];
		end
		fill_table();
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait_cycle();
		expect_equal("ready after reset", status.ready, 1);
		expect_equal("finish after reset", status.finish, 0);
		expect_equal("nack after reset", status.nack, 0);
		expect_equal("SCL after reset", scl, 1);
		expect_equal("SDA drive after reset", master_oe, 0);
		expect_equal("bank nonzero after reset", |rd_bytes, 0);
		for (int i = 0; i < NUM_TESTS; i++)
			run_entry(i);
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/i2c_bus_pkg.sv
rtl/i2c_regs_pkg.sv
rtl/i2c_scl_timer.sv
rtl/i2c_byte_shifter.sv
rtl/i2c_rd_bank.sv
rtl/i2c_seq_fsm.sv
rtl/i2c_master_top.sv
tests/i2c_slave_model.sv
tests/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_i2c_master \
	-Mdir obj_dir -o sim_tb_i2c_master > build.log 2>&1 &&
	./obj_dir/sim_tb_i2c_master > sim.log 2>&1 ||
	{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && { echo "PASS"; exit 0; } ||
	{ echo "FAIL, see sim.log"; exit 1; }
